// ==== compile.f ====
+incdir+verification
hdl/cpu_decode_pkg.sv
hdl/fetch_if.sv
hdl/fetch_unit.sv
hdl/instruction_decoder.sv
hdl/register_scoreboard.sv
hdl/issue_control.sv
hdl/decode_unit.sv
verification/tb_decode_unit.sv

// ==== verification/decode_tests.svh ====
// Word layout op[15:14] ra[13:11] rb[10:8] fn[7:4]
localparam inst_t FENCE_LD  = 16'h3C00;   // LD r7 from r4
localparam inst_t FENCE_OUT = 16'hF8D0;   // OUT r7 stalls on the load

function automatic decoded_t expect_decode(inst_t w);
   decoded_t   d;
   logic [1:0] op;
   reg_addr_t  a;
   reg_addr_t  b;
   logic [3:0] f;
   jump_t      cond [0:7];
   op   = w[15:14];
   a    = w[13:11];
   b    = w[10:8];
   f    = w[7:4];
   cond = '{JMP_EQ, JMP_LT, JMP_LE, JMP_NE, JMP_ALWAYS, JMP_ALWAYS, JMP_ALWAYS, JMP_ALWAYS};
   d        = '0;
   d.ra     = a;
   d.rb     = b;
   d.dest   = (op == 2'd0) ? a : b;
   d.alu_op = ALU_NOP;
   if (op == 2'd0) begin
      d.regwrite  = 1'b1;
      d.src_b     = SRC_B_IMM;
      d.wdata_src = WD_MEM;
      d.mem_read  = 1'b1;
   end else if (op == 2'd1) begin
      d.src_b     = SRC_B_IMM;
      d.mem_write = 1'b1;
   end else if (op == 2'd2) begin
      d.regwrite  = (a == 3'd0) || (a == 3'd1) || (a == 3'd5);
      d.wdata_src = (a == 3'd0) ? WD_IMM : ((a == 3'd5) ? WD_LINK : WD_ALU);
      d.lock      = (a == 3'd3) && !w[0];
      d.unlock    = (a == 3'd3) && w[0];
      if (a == 3'd1) d.alu_op = ALU_ADD;
      if (a == 3'd2) d.alu_op = ALU_CMP;
      if (a != 3'd0 && a != 3'd3) d.src_b = SRC_B_IMM;
      if (a == 3'd4 || a == 3'd5 || a == 3'd7) d.src_a = SRC_A_PC;
      if (a >= 3'd4) d.jump = (a == 3'd7) ? cond[b] : JMP_ALWAYS;
   end else begin
      d.alu_op   = alu_op_t'(f);
      d.regwrite = (f <= 4'd4) || (f == 4'd6) || (f >= 4'd8 && f <= 4'd12);
      if (f == 4'd6 || f == 4'd12) d.src_a = SRC_A_ZERO;
      if (f >= 4'd8 && f <= 4'd11) d.src_b = SRC_B_SHAMT;
      if (f == 4'd12) d.src_b = SRC_B_IMM8;
      d.out_en = (f == 4'd13);
      d.halt   = (f == 4'd15);
   end
   return d;
endfunction

task automatic put(input int addr, input inst_t w);
   mem[addr] = w;
endtask

task automatic load_programs();
   for (int i = 0; i < 256; i++) begin
      mem[i] = 16'(i * 16'h9e37) ^ 16'h5a5a;
   end
   // ALU, shift, MOV, LI, ADDI, LD, ST, CMP
   put(8'h00, 16'hCA00);
   put(8'h01, 16'hC380);
   put(8'h02, 16'hE560);
   put(8'h03, 16'h863C);
   put(8'h04, 16'h8811);
   put(8'h05, 16'h0C05);
   put(8'h06, 16'h6402);
   put(8'h07, 16'hE450);
   put(8'h08, FENCE_LD);
   put(8'h09, FENCE_OUT);
   // B, BAL, BR, BE, BLT, BLE, BNE, LOCK, UNLOCK, OUT
   put(8'h20, 16'hA004);
   put(8'h21, 16'hAE02);
   put(8'h22, 16'hB300);
   put(8'h23, 16'hB801);
   put(8'h24, 16'hB901);
   put(8'h25, 16'hBA01);
   put(8'h26, 16'hBB01);
   put(8'h27, 16'h9800);
   put(8'h28, 16'h9801);
   put(8'h29, 16'hE8D0);
   put(8'h2A, FENCE_LD);
   put(8'h2B, FENCE_OUT);
   put(8'h40, 16'h1400);   // LD r2
   put(8'h41, 16'hD100);   // ADD reading r2
   put(8'h42, FENCE_LD);
   put(8'h43, FENCE_OUT);
   put(8'h50, 16'hCA00);
   put(8'h51, 16'hC380);
   put(8'h52, 16'hE560);
   put(8'h53, 16'h863C);
   put(8'h54, FENCE_LD);
   put(8'h55, FENCE_OUT);
   put(8'h68, 16'h8811);
   put(8'h69, 16'hE450);
   put(8'h6A, FENCE_LD);
   put(8'h6B, FENCE_OUT);
   put(8'h70, 16'hCA00);
   put(8'h71, 16'hC0F0);
   put(8'h72, 16'hC380);
endtask

task automatic step();
   @(posedge clk);
   #2;
endtask

task automatic expect_range(input logic [15:0] lo, input int n);
   for (int i = 0; i < n; i++) begin
      exp_q.push_back(lo + 16'(i));
   end
endtask

task automatic wait_done();
   while (exp_q.size() != 0) @(negedge clk);
   repeat (4) @(negedge clk);
endtask

task automatic retire_one(input reg_addr_t r);
   step();
   retire_valid = 1'b1;
   retire_reg   = r;
   step();
   retire_valid = 1'b0;
   for (int i = 0; i < pending.size(); i++) begin
      if (pending[i] == r) begin
         pending.delete(i);
         break;
      end
   end
endtask

// Leaves issue_ready low so the caller decides when issue resumes
task automatic goto_region(input logic [15:0] addr);
   step();
   issue_ready = 1'b0;
   step();
   flush       = 1'b1;
   redirect_pc = addr;
   step();
   flush = 1'b0;
   while (pending.size() > 0) retire_one(pending[0]);
endtask

task automatic alu_mem_program_order();
   expect_range(16'h00, 9);
   wait_done();
endtask

task automatic branch_lock_out_decode();
   goto_region(16'h20);
   expect_range(16'h20, 11);
   issue_ready = 1'b1;
   wait_done();
endtask

task automatic source_hazard_stall();
   goto_region(16'h40);
   expect_range(16'h40, 1);
   issue_ready = 1'b1;
   wait_done();
   repeat (10) @(negedge clk);   // ADD must stay held, monitor flags it
   retire_one(3'd2);
   expect_range(16'h41, 2);
   wait_done();
endtask

task automatic back_pressure_hold();
   int span;
   goto_region(16'h50);
   expect_range(16'h50, 5);
   issue_ready = 1'b1;
   while (exp_q.size() == 5) @(negedge clk);
   step();
   issue_ready = 1'b0;
   span = ($urandom % 8) + 4;
   step();
   repeat (span) begin
      @(negedge clk);
      if (issue_valid) begin
         $display("Error issue_valid: got %h expected %h while issue_ready low",
                  issue_valid, 1'b0);
         errors++;
      end
   end
   step();
   issue_ready = 1'b1;
   wait_done();
endtask

task automatic flush_redirect_skip();
   goto_region(16'h60);
   repeat (8) step();   // Word at 0x60 now held
   goto_region(16'h68);
   expect_range(16'h68, 3);
   issue_ready = 1'b1;
   wait_done();
endtask

task automatic halt_stops_fetch();
   goto_region(16'h70);
   expect_range(16'h70, 2);
   issue_ready = 1'b1;
   wait_done();
   goto_region(16'h78);   // Empties the held word so only halted keeps fetch idle
   issue_ready = 1'b1;
   repeat (20) @(negedge clk);
   if (halted !== 1'b1) begin
      $display("Error halted: got %h expected %h", halted, 1'b1);
      errors++;
   end
   if (cyc_rises > 1) begin
      $display("Fetch started %0d bus cycles after the halt issued", cyc_rises);
      errors++;
   end
endtask

// ==== verification/tb_decode_unit.sv ====
`timescale 1ns/10ps

module tb_decode_unit;
   import cpu_decode_pkg::*;

   localparam int MAX_CYCLES = 4000;

   logic       clk;
   logic       arst_n;
   logic       wb_cyc;
   logic       wb_stb;
   logic [15:0] wb_adr;
   inst_t      wb_dat_i;
   logic       wb_ack;
   logic       flush;
   logic [15:0] redirect_pc;
   logic       issue_ready;
   logic       retire_valid;
   reg_addr_t  retire_reg;
   logic       issue_valid;
   logic [15:0] issue_pc;
   reg_addr_t  issue_ra;
   reg_addr_t  issue_rb;
   reg_addr_t  issue_dest;
   logic       issue_regwrite;
   alu_op_t    issue_alu_op;
   src_a_t     issue_src_a;
   src_b_t     issue_src_b;
   wdata_src_t issue_wdata_src;
   jump_t      issue_jump;
   logic       issue_mem_read;
   logic       issue_mem_write;
   logic       issue_lock;
   logic       issue_unlock;
   logic       issue_out_en;
   logic       issue_halt;
   logic       halted;

   inst_t       mem [0:255];
   logic [15:0] exp_q[$];       // Pcs still expected to issue in order
   reg_addr_t   pending[$];     // Issued writes not yet retired
   int          errors;
   int          cycles;
   int          ack_wait;
   int          cyc_rises;
   logic        cyc_prev;

   decode_unit #(.ADDR_WIDTH(16), .RESET_PC(16'h0000)) DUT (.*);

   always #20 clk = ~clk;

   `include "decode_tests.svh"

   task automatic compare_field(input string name, input logic [15:0] pc,
                                input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("Error %s at pc %h: got %h expected %h", name, pc, got, exp);
         errors++;
      end
   endtask

   // Wishbone memory acking after 0 to 2 cycles
   always begin
      @(posedge clk);
      #2;
      wb_ack = 1'b0;
      if (arst_n && wb_cyc && wb_stb) begin
         if (ack_wait == 0) begin
            wb_ack   = 1'b1;
            wb_dat_i = mem[wb_adr[7:0]];
            ack_wait = $urandom % 3;
         end else begin
            ack_wait--;
         end
      end
   end

   // Issue monitor checking order and every decoded field
   always @(negedge clk) begin
      logic [15:0] pc;
      decoded_t    e;
      if (arst_n && issue_valid) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected issue of the word at pc %h", issue_pc);
            errors++;
         end else begin
            pc = exp_q.pop_front();
            if (issue_pc !== pc) begin
               $display("Error issue_pc: got %h expected %h", issue_pc, pc);
               errors++;
            end
            e = expect_decode(mem[pc[7:0]]);
            compare_field("issue_ra", pc, issue_ra, e.ra);
            compare_field("issue_rb", pc, issue_rb, e.rb);
            compare_field("issue_dest", pc, issue_dest, e.dest);
            compare_field("issue_regwrite", pc, issue_regwrite, e.regwrite);
            compare_field("issue_alu_op", pc, issue_alu_op, e.alu_op);
            compare_field("issue_src_a", pc, issue_src_a, e.src_a);
            compare_field("issue_src_b", pc, issue_src_b, e.src_b);
            compare_field("issue_wdata_src", pc, issue_wdata_src, e.wdata_src);
            compare_field("issue_jump", pc, issue_jump, e.jump);
            compare_field("issue_mem_read", pc, issue_mem_read, e.mem_read);
            compare_field("issue_mem_write", pc, issue_mem_write, e.mem_write);
            compare_field("issue_lock", pc, issue_lock, e.lock);
            compare_field("issue_unlock", pc, issue_unlock, e.unlock);
            compare_field("issue_out_en", pc, issue_out_en, e.out_en);
            compare_field("issue_halt", pc, issue_halt, e.halt);
            if (e.regwrite) begin
               pending.push_back(e.dest);
            end
         end
      end
      if (arst_n && (wb_stb !== wb_cyc)) begin
         $display("Error wb_stb: got %h expected %h", wb_stb, wb_cyc);
         errors++;
      end
      if (halted && wb_cyc && !cyc_prev) begin
         cyc_rises++;
      end
      cyc_prev = wb_cyc;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout, run stopped after %0d cycles", cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      ack_wait     = $urandom(32'hb819_274d) % 3;   // Seeds the run
      clk          = 1'b0;
      arst_n       = 1'b0;
      wb_dat_i     = '0;
      wb_ack       = 1'b0;
      flush        = 1'b0;
      redirect_pc  = '0;
      issue_ready  = 1'b0;
      retire_valid = 1'b0;
      retire_reg   = '0;
      errors       = 0;
      cycles       = 0;
      cyc_rises    = 0;
      cyc_prev     = 1'b0;
      load_programs();
      repeat (2) @(posedge clk);
      #2;
      arst_n      = 1'b1;
      issue_ready = 1'b1;
      alu_mem_program_order();
      branch_lock_out_decode();
      source_hazard_stall();
      back_pressure_hold();
      flush_redirect_skip();
      halt_stops_fetch();
      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== hdl/decode_unit.sv ====
`timescale 1ns/10ps

module decode_unit #(
   parameter int                    ADDR_WIDTH = 16,
   parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
   input  logic                       clk,
   input  logic                       arst_n,
   output logic                       wb_cyc,
   output logic                       wb_stb,
   output logic [ADDR_WIDTH-1:0]      wb_adr,
   input  cpu_decode_pkg::inst_t      wb_dat_i,
   input  logic                       wb_ack,
   input  logic                       flush,
   input  logic [ADDR_WIDTH-1:0]      redirect_pc,
   input  logic                       issue_ready,
   input  logic                       retire_valid,
   input  cpu_decode_pkg::reg_addr_t  retire_reg,
   output logic                       issue_valid,
   output logic [ADDR_WIDTH-1:0]      issue_pc,
   output cpu_decode_pkg::reg_addr_t  issue_ra,
   output cpu_decode_pkg::reg_addr_t  issue_rb,
   output cpu_decode_pkg::reg_addr_t  issue_dest,
   output logic                       issue_regwrite,
   output cpu_decode_pkg::alu_op_t    issue_alu_op,
   output cpu_decode_pkg::src_a_t     issue_src_a,
   output cpu_decode_pkg::src_b_t     issue_src_b,
   output cpu_decode_pkg::wdata_src_t issue_wdata_src,
   output cpu_decode_pkg::jump_t      issue_jump,
   output logic                       issue_mem_read,
   output logic                       issue_mem_write,
   output logic                       issue_lock,
   output logic                       issue_unlock,
   output logic                       issue_out_en,
   output logic                       issue_halt,
   output logic                       halted
);
   import cpu_decode_pkg::*;

   decoded_t              ctrl;
   decoded_t              issue_ctrl;
   logic [NUM_REGS-1:0]   busy;
   logic [NUM_REGS-1:0]   full;
   logic                  claim;
   reg_addr_t             claim_reg;

   fetch_if #(.ADDR_WIDTH(ADDR_WIDTH)) fetch_bus ();

   fetch_unit #(.ADDR_WIDTH(ADDR_WIDTH), .RESET_PC(RESET_PC)) u_fetch (
      .clk(clk), .arst_n(arst_n),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
      .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
      .flush(flush), .redirect_pc(redirect_pc),
      .halted(halted), .fi(fetch_bus.fetch)
   );

   instruction_decoder u_decode (.fi(fetch_bus.decode), .ctrl(ctrl));

   register_scoreboard u_scoreboard (
      .clk(clk), .arst_n(arst_n),
      .claim(claim), .claim_reg(claim_reg),
      .retire_valid(retire_valid), .retire_reg(retire_reg),
      .busy(busy), .full(full)
   );

   issue_control #(.ADDR_WIDTH(ADDR_WIDTH)) u_issue (
      .clk(clk), .arst_n(arst_n), .fi(fetch_bus.issue),
      .ctrl(ctrl), .busy(busy), .full(full), .issue_ready(issue_ready),
      .claim(claim), .claim_reg(claim_reg),
      .issue_valid(issue_valid), .issue_pc(issue_pc),
      .issue_ctrl(issue_ctrl), .halted(halted)
   );

   // Issue bundle onto plain ports
   assign issue_ra        = issue_ctrl.ra;
   assign issue_rb        = issue_ctrl.rb;
   assign issue_dest      = issue_ctrl.dest;
   assign issue_regwrite  = issue_ctrl.regwrite;
   assign issue_alu_op    = issue_ctrl.alu_op;
   assign issue_src_a     = issue_ctrl.src_a;
   assign issue_src_b     = issue_ctrl.src_b;
   assign issue_wdata_src = issue_ctrl.wdata_src;
   assign issue_jump      = issue_ctrl.jump;
   assign issue_mem_read  = issue_ctrl.mem_read;
   assign issue_mem_write = issue_ctrl.mem_write;
   assign issue_lock      = issue_ctrl.lock;
   assign issue_unlock    = issue_ctrl.unlock;
   assign issue_out_en    = issue_ctrl.out_en;
   assign issue_halt      = issue_ctrl.halt;

endmodule

// ==== hdl/issue_control.sv ====
`timescale 1ns/10ps

module issue_control #(
   parameter int ADDR_WIDTH = 16
) (
   input  logic                                clk,
   input  logic                                arst_n,
   fetch_if.issue                              fi,
   input  cpu_decode_pkg::decoded_t            ctrl,
   input  logic [cpu_decode_pkg::NUM_REGS-1:0] busy,
   input  logic [cpu_decode_pkg::NUM_REGS-1:0] full,
   input  logic                                issue_ready,
   output logic                                claim,
   output cpu_decode_pkg::reg_addr_t           claim_reg,
   output logic                                issue_valid,
   output logic [ADDR_WIDTH-1:0]               issue_pc,
   output cpu_decode_pkg::decoded_t            issue_ctrl,
   output logic                                halted
);
   import cpu_decode_pkg::*;

   logic src_busy;
   logic dest_full;
   logic go;

   assign src_busy  = (ctrl.use_ra && busy[ctrl.ra]) || (ctrl.use_rb && busy[ctrl.rb]);
   assign dest_full = ctrl.regwrite && full[ctrl.dest];

   // Single issue decision for take, claim and the output register
   assign go = fi.valid && issue_ready && !halted && !src_busy && !dest_full;

   assign fi.take   = go;
   assign claim     = go && ctrl.regwrite;
   assign claim_reg = ctrl.dest;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         issue_valid <= 1'b0;
         halted      <= 1'b0;
      end else begin
         issue_valid <= go;
         if (go && ctrl.halt) begin
            halted <= 1'b1;   // Sticky until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      if (go) begin
         issue_pc   <= fi.pc;
         issue_ctrl <= ctrl;
      end
   end

endmodule

// ==== hdl/register_scoreboard.sv ====
`timescale 1ns/10ps

module register_scoreboard (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                claim,
   input  cpu_decode_pkg::reg_addr_t           claim_reg,
   input  logic                                retire_valid,
   input  cpu_decode_pkg::reg_addr_t           retire_reg,
   output logic [cpu_decode_pkg::NUM_REGS-1:0] busy,
   output logic [cpu_decode_pkg::NUM_REGS-1:0] full
);
   import cpu_decode_pkg::*;

   genvar r;

   generate
      for (r = 0; r < NUM_REGS; r++) begin : g_reg
         logic [2:0] count;   // Writes issued, not yet retired
         logic       inc;
         logic       dec;

         assign inc = claim && (claim_reg == reg_addr_t'(r));
         assign dec = retire_valid && (retire_reg == reg_addr_t'(r));

         always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
               count <= 3'd0;
            end else if (inc && !dec) begin
               count <= count + 3'd1;
            end else if (dec && !inc) begin
               count <= count - 3'd1;
            end
         end

         assign busy[r] = |count;
         assign full[r] = &count;   // Limit of 7 outstanding
      end
   endgenerate

endmodule

// ==== hdl/instruction_decoder.sv ====
`timescale 1ns/10ps

module instruction_decoder (
   fetch_if.decode                   fi,
   output cpu_decode_pkg::decoded_t  ctrl
);
   import cpu_decode_pkg::*;

   op_t        op;
   reg_addr_t  ra;
   reg_addr_t  rb;
   logic [3:0] fn;

   assign op = op_t'(fi.inst[15:14]);
   assign ra = fi.inst[13:11];
   assign rb = fi.inst[10:8];
   assign fn = fi.inst[7:4];

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = ALU_NOP;
      ctrl.ra     = ra;
      ctrl.rb     = rb;
      ctrl.dest   = (op == OP_LD) ? ra : rb;   // Loads write ra

      case (op)
         OP_LD: begin
            ctrl.use_rb    = 1'b1;
            ctrl.regwrite  = 1'b1;
            ctrl.src_b     = SRC_B_IMM;
            ctrl.wdata_src = WD_MEM;
            ctrl.mem_read  = 1'b1;
         end
         OP_ST: begin
            ctrl.use_ra    = 1'b1;
            ctrl.use_rb    = 1'b1;
            ctrl.src_b     = SRC_B_IMM;
            ctrl.mem_write = 1'b1;
         end
         OP_IMM: begin
            case (ra)   // ra field is a sub-opcode here
               3'd0: begin // LI
                  ctrl.regwrite  = 1'b1;
                  ctrl.wdata_src = WD_IMM;
               end
               3'd1: begin // ADDI
                  ctrl.use_rb   = 1'b1;
                  ctrl.regwrite = 1'b1;
                  ctrl.alu_op   = ALU_ADD;
                  ctrl.src_b    = SRC_B_IMM;
               end
               3'd2: begin // CMPI
                  ctrl.use_rb = 1'b1;
                  ctrl.alu_op = ALU_CMP;
                  ctrl.src_b  = SRC_B_IMM;
               end
               3'd3: begin
                  if (fi.inst[0]) begin
                     ctrl.unlock = 1'b1;
                  end else begin
                     ctrl.lock = 1'b1;
                  end
               end
               3'd4: begin // B
                  ctrl.jump  = JMP_ALWAYS;
                  ctrl.src_a = SRC_A_PC;
                  ctrl.src_b = SRC_B_IMM;
               end
               3'd5: begin // BAL
                  ctrl.jump      = JMP_ALWAYS;
                  ctrl.src_a     = SRC_A_PC;
                  ctrl.src_b     = SRC_B_IMM;
                  ctrl.regwrite  = 1'b1;
                  ctrl.wdata_src = WD_LINK;
               end
               3'd6: begin // BR
                  ctrl.jump  = JMP_ALWAYS;
                  ctrl.src_b = SRC_B_IMM;
               end
               default: begin
                  ctrl.src_a = SRC_A_PC;
                  ctrl.src_b = SRC_B_IMM;
                  case (rb)   // Condition code
                     3'd0:    ctrl.jump = JMP_EQ;
                     3'd1:    ctrl.jump = JMP_LT;
                     3'd2:    ctrl.jump = JMP_LE;
                     3'd3:    ctrl.jump = JMP_NE;
                     default: ctrl.jump = JMP_ALWAYS;
                  endcase
               end
            endcase
         end
         OP_ALU: begin
            ctrl.alu_op = alu_op_t'(fn);
            case (fn)
               4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                  ctrl.use_ra   = 1'b1;
                  ctrl.use_rb   = 1'b1;
                  ctrl.regwrite = 1'b1;
               end
               4'd5: begin // CMP sets flags only
                  ctrl.use_ra = 1'b1;
                  ctrl.use_rb = 1'b1;
               end
               4'd6: begin // MOV
                  ctrl.use_ra   = 1'b1;
                  ctrl.src_a    = SRC_A_ZERO;
                  ctrl.regwrite = 1'b1;
               end
               4'd8, 4'd9, 4'd10, 4'd11: begin
                  ctrl.use_rb   = 1'b1;
                  ctrl.regwrite = 1'b1;
                  ctrl.src_b    = SRC_B_SHAMT;
               end
               4'd12: begin
                  ctrl.regwrite = 1'b1;
                  ctrl.src_a    = SRC_A_ZERO;
                  ctrl.src_b    = SRC_B_IMM8;
               end
               4'd13: begin // OUT
                  ctrl.use_ra = 1'b1;
                  ctrl.out_en = 1'b1;
               end
               4'd15: begin
                  ctrl.halt = 1'b1;
               end
               default: begin
                  ctrl.halt = 1'b0;   // Code 7 and 14 unused
               end
            endcase
         end
      endcase
   end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit #(
   parameter int                    ADDR_WIDTH = 16,
   parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
   input  logic                  clk,
   input  logic                  arst_n,
   output logic                  wb_cyc,
   output logic                  wb_stb,
   output logic [ADDR_WIDTH-1:0] wb_adr,
   input  cpu_decode_pkg::inst_t wb_dat_i,
   input  logic                  wb_ack,
   input  logic                  flush,
   input  logic [ADDR_WIDTH-1:0] redirect_pc,
   input  logic                  halted,
   fetch_if.fetch                fi
);
   import cpu_decode_pkg::*;

   logic [ADDR_WIDTH-1:0] pc;       // Next address to request
   logic [ADDR_WIDTH-1:0] adr;
   logic                  cyc;
   logic                  drop;     // In-flight data belongs to old stream
   logic                  ir_full;
   inst_t                 ir;
   logic [ADDR_WIDTH-1:0] ir_pc;
   logic                  start;
   logic                  accept;

   // One word held, one request in flight at most
   assign start  = !cyc && !halted && !flush && (!ir_full || fi.take);
   assign accept = cyc && wb_ack && !drop && !flush;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cyc     <= 1'b0;
         drop    <= 1'b0;
         ir_full <= 1'b0;
         pc      <= RESET_PC;
      end else begin
         if (start) begin
            cyc <= 1'b1;
         end else if (cyc && wb_ack) begin
            cyc <= 1'b0;
         end

         if (cyc && wb_ack) begin
            drop <= 1'b0;
         end else if (cyc && flush) begin
            drop <= 1'b1;   // Let the cycle finish, discard its data
         end

         if (flush) begin
            ir_full <= 1'b0;
            pc      <= redirect_pc;
         end else if (accept) begin
            ir_full <= 1'b1;
            pc      <= pc + 1'b1;
         end else if (fi.take) begin
            ir_full <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         adr <= pc;   // Held stable until ack
      end
      if (accept) begin
         ir    <= wb_dat_i;
         ir_pc <= adr;
      end
   end

   assign wb_cyc = cyc;
   assign wb_stb = cyc;
   assign wb_adr = adr;

   assign fi.valid = ir_full && !flush;
   assign fi.inst  = ir;
   assign fi.pc    = ir_pc;

endmodule

// ==== hdl/fetch_if.sv ====
`timescale 1ns/10ps

interface fetch_if #(
   parameter int ADDR_WIDTH = 16
);
   import cpu_decode_pkg::*;

   logic                  valid;   // Word held and not flushed
   inst_t                 inst;
   logic [ADDR_WIDTH-1:0] pc;
   logic                  take;    // Consumer accepts this cycle

   modport fetch  (output valid, output inst, output pc, input take);
   modport decode (input inst);
   modport issue  (input valid, input pc, output take);

endinterface

// ==== hdl/cpu_decode_pkg.sv ====
package cpu_decode_pkg;

   localparam int NUM_REGS = 8;   // Fixed by the instruction set

   typedef logic [15:0] inst_t;
   typedef logic [2:0]  reg_addr_t;

   // Major opcode, top two bits of the word
   typedef enum logic [1:0] {
      OP_LD  = 2'd0,
      OP_ST  = 2'd1,
      OP_IMM = 2'd2,   // Immediates, lock and branches
      OP_ALU = 2'd3
   } op_t;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_CMP  = 4'd5,
      ALU_MOV  = 4'd6,
      ALU_SLL  = 4'd8,
      ALU_SLR  = 4'd9,
      ALU_SRL  = 4'd10,
      ALU_SRA  = 4'd11,
      ALU_LDIH = 4'd12,
      ALU_NOP  = 4'd15
   } alu_op_t;

   typedef enum logic [1:0] {
      SRC_A_REG  = 2'd0,
      SRC_A_PC   = 2'd1,
      SRC_A_ZERO = 2'd2
   } src_a_t;

   typedef enum logic [1:0] {
      SRC_B_REG   = 2'd0,
      SRC_B_SHAMT = 2'd1,
      SRC_B_IMM   = 2'd2,
      SRC_B_IMM8  = 2'd3
   } src_b_t;

   typedef enum logic [1:0] {
      WD_ALU  = 2'd0,
      WD_MEM  = 2'd1,
      WD_LINK = 2'd2,
      WD_IMM  = 2'd3
   } wdata_src_t;

   typedef enum logic [2:0] {
      JMP_NONE   = 3'd0,
      JMP_ALWAYS = 3'd1,
      JMP_EQ     = 3'd2,
      JMP_LT     = 3'd3,
      JMP_LE     = 3'd4,
      JMP_NE     = 3'd5
   } jump_t;

   typedef struct packed {
      logic       use_ra;
      logic       use_rb;
      reg_addr_t  ra;
      reg_addr_t  rb;
      reg_addr_t  dest;
      logic       regwrite;
      alu_op_t    alu_op;
      src_a_t     src_a;
      src_b_t     src_b;
      wdata_src_t wdata_src;
      jump_t      jump;
      logic       mem_read;
      logic       mem_write;
      logic       lock;
      logic       unlock;
      logic       out_en;
      logic       halt;
   } decoded_t;

endpackage
